// ==== bru_dq.f ====
+incdir+include
rtl/core_types_pkg.sv
rtl/bru_dq_pkg.sv
rtl/dispatch_alloc.sv
rtl/wb_wakeup.sv
rtl/bru_dq.sv
rtl/bru_dq_wrapper.sv
testbench/bru_dq_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch dispatch queue testbench
# override from the command line, e.g. make run ENTRIES=8

VERILATOR ?= verilator
TOP ?= bru_dq_tb
ENTRIES ?= 4
FILELIST ?= bru_dq.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GBRU_DQ_ENTRIES=$(ENTRIES) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== include/bru_dq_tb_model.svh ====
// ------------------------------
// reference rules for the branch dispatch queue
// include inside a module, after the packages are compiled
// ------------------------------

`ifndef BRU_DQ_TB_MODEL_SVH
`define BRU_DQ_TB_MODEL_SVH

// acks for the attempting ways, lowest first, limited by the free count
function automatic logic [core_types_pkg::DISPATCH_WAYS-1:0] expected_ack(
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] attempt,
	input int free_count
);
	logic [core_types_pkg::DISPATCH_WAYS-1:0] ack;
	int seen;
	ack = '0;
	seen = 0;
	for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
		if (attempt[w]) begin
			seen++;
			if (seen <= free_count) ack[w] = 1'b1;
		end
	end
	return ack;
endfunction

// register woken when its own bank's slot is valid with equal upper bits
function automatic logic wb_match(
	input core_types_pkg::pr_t pr,
	input bru_dq_pkg::wb_slot_t [core_types_pkg::PRF_BANK_COUNT-1:0] bus
);
	bru_dq_pkg::wb_slot_t slot;
	slot = bus[pr[core_types_pkg::LOG_PRF_BANK_COUNT-1:0]];
	return slot.valid &&
		slot.upper_pr == pr[core_types_pkg::LOG_PR_COUNT-1:core_types_pkg::LOG_PRF_BANK_COUNT];
endfunction

`endif

// ==== testbench/bru_dq_tb.sv ====
// ------------------------------
// testbench for bru_dq_wrapper
// the model lags the driven inputs by two edges, like the wrapper stages
// an op is compared when it is popped, i.e. when the ready driven two
// edges earlier was high and the model holds an op
// ------------------------------

module bru_dq_tb #(
	parameter int BRU_DQ_ENTRIES = 4
);

	localparam int WAYS = core_types_pkg::DISPATCH_WAYS;
	localparam int BANKS = core_types_pkg::PRF_BANK_COUNT;
	localparam int DRAIN_TIMEOUT = 300;

	typedef logic [WAYS-1:0] way_mask_t;
	typedef bru_dq_pkg::bru_op_t [WAYS-1:0] way_ops_t;
	typedef bru_dq_pkg::wb_slot_t [BANKS-1:0] wb_bus_t;

	// inputs driven in one cycle
	typedef struct packed {
		way_mask_t attempt;
		way_mask_t valid;
		way_ops_t ops;
		wb_bus_t wb;
		logic ready;
	} stim_t;

	`include "bru_dq_tb_model.svh"

	logic CLK;
	logic nRST;
	way_mask_t next_dispatch_attempt_by_way;
	way_mask_t next_dispatch_valid_by_way;
	way_ops_t next_dispatch_op_by_way;
	way_mask_t last_dispatch_ack_by_way;
	wb_bus_t next_wb_bus_by_bank;
	logic last_iq_enq_valid;
	bru_dq_pkg::bru_op_t last_iq_enq_op;
	logic next_iq_enq_ready;

	logic [31:0] lcg_state;
	string test_name = "reset";
	bru_dq_pkg::bru_op_t model_q [$];
	stim_t stage0 = '0;
	stim_t stage1 = '0;
	stim_t stage2 = '0;
	int ack_errors = 0;
	int op_errors = 0;
	int valid_errors = 0;
	int timeout_errors = 0;
	int ops_checked = 0;

	bru_dq_wrapper #(.BRU_DQ_ENTRIES(BRU_DQ_ENTRIES)) u_bru_dq_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.next_dispatch_attempt_by_way(next_dispatch_attempt_by_way),
		.next_dispatch_valid_by_way(next_dispatch_valid_by_way),
		.next_dispatch_op_by_way(next_dispatch_op_by_way),
		.last_dispatch_ack_by_way(last_dispatch_ack_by_way),
		.next_wb_bus_by_bank(next_wb_bus_by_bank),
		.last_iq_enq_valid(last_iq_enq_valid),
		.last_iq_enq_op(last_iq_enq_op),
		.next_iq_enq_ready(next_iq_enq_ready)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	// ------------------------------
	// stimulus helpers
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bru_dq_pkg::bru_op_t random_op();
		logic [159:0] raw;
		raw = {lcg_next(), lcg_next(), lcg_next(), lcg_next(), lcg_next()};
		return raw[$bits(bru_dq_pkg::bru_op_t)-1:0];
	endfunction

	function automatic core_types_pkg::pr_t make_pr(input int upper, input int bank);
		return {core_types_pkg::upper_pr_t'(upper), bank[core_types_pkg::LOG_PRF_BANK_COUNT-1:0]};
	endfunction

	function automatic stim_t idle_stim(input logic ready);
		stim_t s;
		s = '0;
		s.ready = ready;
		return s;
	endfunction

	// small register range so writebacks hit often
	function automatic stim_t random_stim(input logic ready);
		stim_t s;
		logic [31:0] r;
		r = lcg_next();
		s.attempt = r[WAYS-1:0];
		s.valid = r[2*WAYS-1:WAYS];
		for (int w = 0; w < WAYS; w++) begin
			s.ops[w] = random_op();
			s.ops[w].a_pr = s.ops[w].a_pr & 7'h0f;
			s.ops[w].b_pr = s.ops[w].b_pr & 7'h0f;
		end
		for (int b = 0; b < BANKS; b++) begin
			r = lcg_next();
			s.wb[b].valid = r[31];
			s.wb[b].upper_pr = core_types_pkg::upper_pr_t'(r[1:0]);
		end
		s.ready = ready;
		return s;
	endfunction

	// operands woken by one cycle of writeback
	function automatic bru_dq_pkg::bru_op_t wake(input bru_dq_pkg::bru_op_t op, input wb_bus_t bus);
		bru_dq_pkg::bru_op_t res;
		res = op;
		res.a_ready = op.a_ready | wb_match(op.a_pr, bus);
		res.b_ready = op.b_ready | wb_match(op.b_pr, bus);
		return res;
	endfunction

	task automatic drive(input stim_t s);
		@(posedge CLK);
		next_dispatch_attempt_by_way <= s.attempt;
		next_dispatch_valid_by_way <= s.valid;
		next_dispatch_op_by_way <= s.ops;
		next_wb_bus_by_bank <= s.wb;
		next_iq_enq_ready <= s.ready;
	endtask

	// idle with ready high until the model is empty
	task automatic drain();
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		while (!done && waited < DRAIN_TIMEOUT) begin
			drive(idle_stim(1'b1));
			waited++;
			if (waited >= 3 && model_q.size() == 0) done = 1'b1;
		end
		if (!done) begin
			timeout_errors++;
			$display("timeout in %s: queue still holds %0d ops after %0d cycles",
				test_name, model_q.size(), DRAIN_TIMEOUT);
		end
	endtask

	// ------------------------------
	// compare tasks
	task automatic check_ack(input string name, input way_mask_t expected, input way_mask_t actual);
		if (actual !== expected) begin
			ack_errors++;
			$display("FAIL %s ack: expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			valid_errors++;
			$display("FAIL %s iq valid: expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic check_op(input string name, input bru_dq_pkg::bru_op_t expected,
		input bru_dq_pkg::bru_op_t actual);
		if (actual !== expected) begin
			op_errors++;
			$display("FAIL %s iq op: expected %h actual %h", name, expected, actual);
		end
	endtask

	// ------------------------------
	// monitor and model, outputs sampled at the falling edge
	always @(negedge CLK) begin
		stim_t cur;
		way_mask_t exp_ack;
		bru_dq_pkg::bru_op_t op;
		int free_count;
		cur.attempt = next_dispatch_attempt_by_way;
		cur.valid = next_dispatch_valid_by_way;
		cur.ops = next_dispatch_op_by_way;
		cur.wb = next_wb_bus_by_bank;
		cur.ready = next_iq_enq_ready;
		stage2 = stage1;
		stage1 = stage0;
		stage0 = cur;
		// slots popped this cycle are not free yet
		free_count = BRU_DQ_ENTRIES - model_q.size();
		exp_ack = expected_ack(stage2.attempt, free_count);
		check_ack(test_name, exp_ack, last_dispatch_ack_by_way);
		check_valid(test_name, model_q.size() != 0, last_iq_enq_valid);
		for (int i = 0; i < model_q.size(); i++) begin
			model_q[i] = wake(model_q[i], stage2.wb);
		end
		if (stage2.ready && model_q.size() != 0) begin
			op = model_q.pop_front();
			check_op(test_name, op, last_iq_enq_op);
			ops_checked++;
		end
		for (int w = 0; w < WAYS; w++) begin
			if (exp_ack[w] && stage2.valid[w]) begin
				model_q.push_back(wake(stage2.ops[w], stage2.wb));
			end
		end
	end

	// ------------------------------
	// test sequence
	initial begin
		stim_t s;
		logic [31:0] r;
		int total;
		lcg_state = 32'h0f2a302e;
		nRST = 1'b0;
		next_dispatch_attempt_by_way = '0;
		next_dispatch_valid_by_way = '0;
		next_dispatch_op_by_way = '0;
		next_wb_bus_by_bank = '0;
		next_iq_enq_ready = 1'b0;
		repeat (10) @(posedge CLK);
		nRST <= 1'b1;

		// nothing dispatched, outputs must stay low
		repeat (6) drive(idle_stim(1'b1));

		test_name = "order";
		for (int i = 0; i < 80; i++) drive(random_stim(1'b1));
		drain();

		test_name = "fullness";
		for (int i = 0; i < 6; i++) begin
			s = random_stim(1'b0);
			s.attempt = '1;
			s.valid = '1;
			s.wb = '0;
			drive(s);
		end
		repeat (3) drive(idle_stim(1'b0));
		drain();

		// wrong-bank cases: way2 a and way3 b carry an upper value seen in another bank
		test_name = "wakeup";
		s = idle_stim(1'b0);
		s.attempt = '1;
		s.valid = '1;
		for (int w = 0; w < WAYS; w++) begin
			s.ops[w] = random_op();
			s.ops[w].a_ready = 1'b0;
			s.ops[w].b_ready = 1'b0;
		end
		s.ops[0].a_pr = make_pr(3, 1);
		s.ops[0].b_pr = make_pr(3, 2);
		s.ops[1].a_pr = make_pr(6, 0);
		s.ops[1].b_pr = make_pr(9, 3);
		s.ops[2].a_pr = make_pr(12, 1);
		s.ops[2].b_pr = make_pr(7, 2);
		s.ops[3].a_pr = make_pr(20, 3);
		s.ops[3].b_pr = make_pr(21, 0);
		drive(s);
		repeat (2) drive(idle_stim(1'b0));
		s = idle_stim(1'b0);
		s.wb[0] = '{valid: 1'b1, upper_pr: 5'd6};
		s.wb[1] = '{valid: 1'b1, upper_pr: 5'd3};
		s.wb[2] = '{valid: 1'b1, upper_pr: 5'd12};
		s.wb[3] = '{valid: 1'b1, upper_pr: 5'd21};
		drive(s);
		repeat (2) drive(idle_stim(1'b0));
		drain();

		test_name = "backpressure";
		for (int i = 0; i < 250; i++) begin
			r = lcg_next();
			drive(random_stim(r[7]));
		end
		drain();
		repeat (4) drive(idle_stim(1'b1));

		if (ops_checked == 0) begin
			op_errors++;
			$display("no op ever reached the issue queue side");
		end
		total = ack_errors + op_errors + valid_errors + timeout_errors;
		$display("errors: ack %0d, op %0d, valid %0d, timeout %0d (ops checked %0d)",
			ack_errors, op_errors, valid_errors, timeout_errors, ops_checked);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/bru_dq_wrapper.sv ====
// ------------------------------
// top level, one register stage on every queue input and output
// acks come back one cycle after the inputs are sampled
// head shown one cycle late, ready acts two edges after it is driven
// ------------------------------

module bru_dq_wrapper #(
	parameter int BRU_DQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_attempt_by_way,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_valid_by_way,
	input bru_dq_pkg::bru_op_t [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_op_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] last_dispatch_ack_by_way,
	input bru_dq_pkg::wb_slot_t [core_types_pkg::PRF_BANK_COUNT-1:0] next_wb_bus_by_bank,
	output logic last_iq_enq_valid,
	output bru_dq_pkg::bru_op_t last_iq_enq_op,
	input logic next_iq_enq_ready
);

	// queue side of the register stage
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_valid_by_way;
	bru_dq_pkg::bru_op_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_op_by_way;
	logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way;
	bru_dq_pkg::wb_slot_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_by_bank;
	logic iq_enq_valid;
	bru_dq_pkg::bru_op_t iq_enq_op;
	logic iq_enq_ready;

	bru_dq #(.BRU_DQ_ENTRIES(BRU_DQ_ENTRIES)) u_bru_dq (
		.CLK(CLK),
		.nRST(nRST),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_valid_by_way(dispatch_valid_by_way),
		.dispatch_op_by_way(dispatch_op_by_way),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.wb_bus_by_bank(wb_bus_by_bank),
		.iq_enq_valid(iq_enq_valid),
		.iq_enq_op(iq_enq_op),
		.iq_enq_ready(iq_enq_ready)
	);

	// ------------------------------
	// timing isolation registers
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			dispatch_attempt_by_way <= '0;
			dispatch_valid_by_way <= '0;
			dispatch_op_by_way <= '0;
			wb_bus_by_bank <= '0;
			iq_enq_ready <= 1'b0;
			last_dispatch_ack_by_way <= '0;
			last_iq_enq_valid <= 1'b0;
			last_iq_enq_op <= '0;
		end else begin
			// inputs
			dispatch_attempt_by_way <= next_dispatch_attempt_by_way;
			dispatch_valid_by_way <= next_dispatch_valid_by_way;
			dispatch_op_by_way <= next_dispatch_op_by_way;
			wb_bus_by_bank <= next_wb_bus_by_bank;
			iq_enq_ready <= next_iq_enq_ready;
			// outputs
			last_dispatch_ack_by_way <= dispatch_ack_by_way;
			last_iq_enq_valid <= iq_enq_valid;
			last_iq_enq_op <= iq_enq_op;
		end
	end

endmodule

// ==== rtl/bru_dq.sv ====
// ------------------------------
// branch dispatch queue, circular buffer in program order
// BRU_DQ_ENTRIES from 2 to 16, any value (explicit pointer wrap)
// entries popped this cycle are not free for dispatch this cycle
// operand ready bits set by writeback matches while an op waits
// ------------------------------

module bru_dq #(
	parameter int BRU_DQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_valid_by_way,
	input bru_dq_pkg::bru_op_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_op_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,
	input bru_dq_pkg::wb_slot_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_by_bank,
	output logic iq_enq_valid,
	output bru_dq_pkg::bru_op_t iq_enq_op,
	input logic iq_enq_ready
);

	localparam int WAYS = core_types_pkg::DISPATCH_WAYS;
	localparam int PTR_W = $clog2(BRU_DQ_ENTRIES);

	typedef logic [PTR_W-1:0] ptr_t;

	// pointer plus offset, wrapped into the entry range
	function automatic ptr_t wrap_add(input ptr_t a, input bru_dq_pkg::dq_count_t b);
		bru_dq_pkg::dq_count_t sum;
		sum = bru_dq_pkg::dq_count_t'(a) + b;
		if (sum >= bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES)) begin
			sum = sum - bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES);
		end
		return ptr_t'(sum);
	endfunction

	// ------------------------------
	// state
	bru_dq_pkg::bru_op_t entry_q [BRU_DQ_ENTRIES];
	logic [BRU_DQ_ENTRIES-1:0] valid_q;
	ptr_t head_q;
	ptr_t tail_q;
	bru_dq_pkg::dq_count_t count_q;

	bru_dq_pkg::dq_count_t free_count;
	logic [WAYS-1:0] alloc_by_way;
	bru_dq_pkg::dq_count_t [WAYS-1:0] alloc_offset_by_way;
	bru_dq_pkg::dq_count_t alloc_count;
	ptr_t way_slot [WAYS];
	bru_dq_pkg::bru_op_t way_op_woken [WAYS];
	logic [WAYS-1:0] way_a_match;
	logic [WAYS-1:0] way_b_match;
	logic [BRU_DQ_ENTRIES-1:0] entry_a_match;
	logic [BRU_DQ_ENTRIES-1:0] entry_b_match;
	logic [BRU_DQ_ENTRIES-1:0] entry_write;
	bru_dq_pkg::bru_op_t write_op [BRU_DQ_ENTRIES];
	bru_dq_pkg::bru_op_t head_op;
	logic head_a_match;
	logic head_b_match;
	logic pop;

	assign free_count = bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES) - count_q;

	dispatch_alloc #(.BRU_DQ_ENTRIES(BRU_DQ_ENTRIES)) u_dispatch_alloc (
		.attempt_by_way(dispatch_attempt_by_way),
		.valid_by_way(dispatch_valid_by_way),
		.free_count(free_count),
		.ack_by_way(dispatch_ack_by_way),
		.alloc_by_way(alloc_by_way),
		.alloc_offset_by_way(alloc_offset_by_way),
		.alloc_count(alloc_count)
	);

	// ------------------------------
	// incoming ways, woken by same-cycle writeback
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		wb_wakeup u_a_wakeup (.pr(dispatch_op_by_way[w].a_pr), .wb_bus_by_bank, .match(way_a_match[w]));
		wb_wakeup u_b_wakeup (.pr(dispatch_op_by_way[w].b_pr), .wb_bus_by_bank, .match(way_b_match[w]));

		assign way_slot[w] = wrap_add(tail_q, alloc_offset_by_way[w]);

		always_comb begin
			way_op_woken[w] = dispatch_op_by_way[w];
			way_op_woken[w].a_ready = dispatch_op_by_way[w].a_ready | way_a_match[w];
			way_op_woken[w].b_ready = dispatch_op_by_way[w].b_ready | way_b_match[w];
		end
	end

	// stored operands
	for (genvar e = 0; e < BRU_DQ_ENTRIES; e++) begin : g_entry
		wb_wakeup u_a_wakeup (.pr(entry_q[e].a_pr), .wb_bus_by_bank, .match(entry_a_match[e]));
		wb_wakeup u_b_wakeup (.pr(entry_q[e].b_pr), .wb_bus_by_bank, .match(entry_b_match[e]));
	end

	// route each allocated way to its entry
	always_comb begin
		for (int e = 0; e < BRU_DQ_ENTRIES; e++) begin
			entry_write[e] = 1'b0;
			write_op[e] = '0;
			for (int w = 0; w < WAYS; w++) begin
				if (alloc_by_way[w] && way_slot[w] == ptr_t'(e)) begin
					entry_write[e] = 1'b1;
					write_op[e] = way_op_woken[w];
				end
			end
		end
	end

	// ------------------------------
	// control state
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (pop) begin
				valid_q[head_q] <= 1'b0;
				head_q <= wrap_add(head_q, bru_dq_pkg::dq_count_t'(1));
			end
			// new slots never collide with the popped head
			for (int w = 0; w < WAYS; w++) begin
				if (alloc_by_way[w]) begin
					valid_q[way_slot[w]] <= 1'b1;
				end
			end
			tail_q <= wrap_add(tail_q, alloc_count);
			count_q <= count_q + alloc_count - bru_dq_pkg::dq_count_t'(pop);
		end
	end

	// entry payload
	always_ff @(posedge CLK) begin
		for (int e = 0; e < BRU_DQ_ENTRIES; e++) begin
			if (entry_write[e]) begin
				entry_q[e] <= write_op[e];
			end else begin
				if (entry_a_match[e]) entry_q[e].a_ready <= 1'b1;
				if (entry_b_match[e]) entry_q[e].b_ready <= 1'b1;
			end
		end
	end

	// ------------------------------
	// head toward the issue queue
	assign head_op = entry_q[head_q];

	wb_wakeup u_head_a_wakeup (.pr(head_op.a_pr), .wb_bus_by_bank, .match(head_a_match));
	wb_wakeup u_head_b_wakeup (.pr(head_op.b_pr), .wb_bus_by_bank, .match(head_b_match));

	always_comb begin
		iq_enq_op = head_op;
		iq_enq_op.a_ready = head_op.a_ready | head_a_match;
		iq_enq_op.b_ready = head_op.b_ready | head_b_match;
	end

	assign iq_enq_valid = valid_q[head_q];
	assign pop = iq_enq_valid & iq_enq_ready;

	// ------------------------------
	// checks
	a_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
		count_q <= bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES));
	a_valid_matches_count: assert property (@(posedge CLK) disable iff (!nRST)
		iq_enq_valid == (count_q != '0));
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
		pop |-> count_q != '0);
	a_ack_in_attempt: assert property (@(posedge CLK) disable iff (!nRST)
		(dispatch_ack_by_way & ~dispatch_attempt_by_way) == '0);

endmodule

// ==== rtl/wb_wakeup.sv ====
// ------------------------------
// writeback match for one physical register
// bank taken from the low bits, upper bits compared to that bank's slot
// ------------------------------

module wb_wakeup (
	input core_types_pkg::pr_t pr,
	input bru_dq_pkg::wb_slot_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_by_bank,
	output logic match
);

	logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] bank;
	core_types_pkg::upper_pr_t upper;
	bru_dq_pkg::wb_slot_t slot;

	// split register index
	assign bank = pr[core_types_pkg::LOG_PRF_BANK_COUNT-1:0];
	assign upper = pr[core_types_pkg::LOG_PR_COUNT-1:core_types_pkg::LOG_PRF_BANK_COUNT];

	// only this register's bank can carry its writeback
	assign slot = wb_bus_by_bank[bank];
	assign match = slot.valid & (slot.upper_pr == upper);

endmodule

// ==== rtl/dispatch_alloc.sv ====
// ------------------------------
// dispatch acknowledge and slot allocation
// ways are served lowest first, acks form a prefix of the attempting ways
// an acked way that is not valid uses ack budget but takes no entry
// purely combinational
// ------------------------------

module dispatch_alloc #(
	parameter int BRU_DQ_ENTRIES = 4
) (
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] attempt_by_way,
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] valid_by_way,
	input bru_dq_pkg::dq_count_t free_count,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] ack_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] alloc_by_way,
	output bru_dq_pkg::dq_count_t [core_types_pkg::DISPATCH_WAYS-1:0] alloc_offset_by_way,
	output bru_dq_pkg::dq_count_t alloc_count
);

	bru_dq_pkg::dq_count_t free_eff;
	bru_dq_pkg::dq_count_t attempt_cnt;
	bru_dq_pkg::dq_count_t taken_cnt;
	logic refused;

	// free count can never legally exceed the queue size
	assign free_eff = (free_count > bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES)) ?
		bru_dq_pkg::dq_count_t'(BRU_DQ_ENTRIES) : free_count;

	always_comb begin
		attempt_cnt = '0;
		taken_cnt = '0;
		refused = 1'b0;
		for (int w = 0; w < core_types_pkg::DISPATCH_WAYS; w++) begin
			ack_by_way[w] = 1'b0;
			alloc_by_way[w] = 1'b0;
			// offset from tail = valid acked ways below this one
			alloc_offset_by_way[w] = taken_cnt;
			if (attempt_by_way[w]) begin
				attempt_cnt = attempt_cnt + bru_dq_pkg::dq_count_t'(1);
				if (!refused && attempt_cnt <= free_eff) begin
					ack_by_way[w] = 1'b1;
				end else begin
					refused = 1'b1;
				end
			end
			if (ack_by_way[w] && valid_by_way[w]) begin
				alloc_by_way[w] = 1'b1;
				taken_cnt = taken_cnt + bru_dq_pkg::dq_count_t'(1);
			end
		end
		alloc_count = taken_cnt;
	end

endmodule

// ==== rtl/bru_dq_pkg.sv ====
// ------------------------------
// types carried by the branch dispatch queue
// dq_count_t holds 0 to 16, so queues of up to 16 entries
// ------------------------------

package bru_dq_pkg;

	localparam int MAX_DQ_ENTRIES = 16;

	// occupancy, free count and tail offsets
	typedef logic [$clog2(MAX_DQ_ENTRIES+1)-1:0] dq_count_t;

	// ------------------------------
	// one branch op as it leaves rename/dispatch
	typedef struct packed {
		core_types_pkg::bru_op_code_t op;
		core_types_pkg::pred_info_t pred_info;
		logic pred_lru;
		logic is_link_ra;
		logic is_ret_ra;
		core_types_pkg::pc_t pc;
		core_types_pkg::pc_t pred_pc;
		core_types_pkg::imm20_t imm20;
		// source operand a
		core_types_pkg::pr_t a_pr;
		logic a_ready;
		logic a_unneeded_or_is_zero;
		// source operand b
		core_types_pkg::pr_t b_pr;
		logic b_ready;
		logic b_unneeded_or_is_zero;
		core_types_pkg::pr_t dest_pr;
		core_types_pkg::rob_index_t rob_index;
	} bru_op_t;

	// one bank of the writeback bus
	typedef struct packed {
		logic valid;
		core_types_pkg::upper_pr_t upper_pr;
	} wb_slot_t;

endpackage

// ==== rtl/core_types_pkg.sv ====
// ------------------------------
// processor-wide widths and counts
// the low LOG_PRF_BANK_COUNT bits of a physical register name its bank
// bank count must stay a power of two
// ------------------------------

package core_types_pkg;

	// ------------------------------
	// widths and counts
	localparam int DISPATCH_WAYS = 4;
	localparam int LOG_PR_COUNT = 7;
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int LOG_ROB_ENTRIES = 7;
	localparam int BTB_PRED_INFO_WIDTH = 8;

	// ------------------------------
	// named vector types
	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	// register index with the bank bits stripped
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
	typedef logic [31:0] pc_t;
	typedef logic [19:0] imm20_t;
	// opaque to the queue, passed through as is
	typedef logic [3:0] bru_op_code_t;
	typedef logic [BTB_PRED_INFO_WIDTH-1:0] pred_info_t;

endpackage
